//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim
	./obj_dir/rv_core_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/operand_forward.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module operand_forward (
    input  logic [`REG_AW-1:0] rs_addr,
    input  logic [`XLEN-1:0]   rf_data,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    output logic [`XLEN-1:0]   src_data
);

    logic hit;

    // wb_we is already low for rd = x0, so x0 never forwards
    assign hit = wb_we && (wb_rd == rs_addr);

    always_comb begin
        if (hit) begin
            src_data = wb_data;             // result not yet in the register file
        end else begin
            src_data = rf_data;
        end
    end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_core import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req,
    input  logic [`XLEN-1:0]   insn,
    input  logic [`XLEN-1:0]   pc,
    output logic               ack,
    output logic               retire_valid,
    output logic [`REG_AW-1:0] retire_rd,
    output logic               retire_we,
    output logic [`XLEN-1:0]   retire_data,
    output logic               retire_br_taken,
    output logic [`XLEN-1:0]   retire_br_addr,
    output logic               retire_undef
);

    logic [`REG_AW-1:0] rs_addr  [2];
    logic [`XLEN-1:0]   rf_data  [2];
    logic [`XLEN-1:0]   src_data [2];
    logic               id_valid;
    alu_op_e            alu_op;
    opa_sel_e           opa_sel;
    opb_sel_e           opb_sel;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   id_pc;
    br_kind_e           br_kind;
    br_cond_e           br_cond;
    logic [`REG_AW-1:0] rd;
    logic               rd_we;
    logic               undef;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_rd;
    logic [`XLEN-1:0]   wb_data;

    rv_decoder u_decoder (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .insn     (insn),
        .pc       (pc),
        .ack      (ack),
        .rs_addr  (rs_addr),
        .id_valid (id_valid),
        .alu_op   (alu_op),
        .opa_sel  (opa_sel),
        .opb_sel  (opb_sel),
        .imm      (imm),
        .id_pc    (id_pc),
        .br_kind  (br_kind),
        .br_cond  (br_cond),
        .rd       (rd),
        .rd_we    (rd_we),
        .undef    (undef)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (rs_addr),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rf_data (rf_data)
    );

    // one bypass per source operand
    for (genvar i = 0; i < 2; i++) begin : g_fwd
        operand_forward u_fwd (
            .rs_addr  (rs_addr[i]),
            .rf_data  (rf_data[i]),
            .wb_we    (wb_we),
            .wb_rd    (wb_rd),
            .wb_data  (wb_data),
            .src_data (src_data[i])
        );
    end

    rv_execute u_execute (
        .clk             (clk),
        .arst_n          (arst_n),
        .id_valid        (id_valid),
        .alu_op          (alu_op),
        .opa_sel         (opa_sel),
        .opb_sel         (opb_sel),
        .imm             (imm),
        .id_pc           (id_pc),
        .br_kind         (br_kind),
        .br_cond         (br_cond),
        .rd              (rd),
        .rd_we           (rd_we),
        .undef           (undef),
        .src_data        (src_data),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_we       (retire_we),
        .retire_data     (retire_data),
        .retire_br_taken (retire_br_taken),
        .retire_br_addr  (retire_br_addr),
        .retire_undef    (retire_undef)
    );

endmodule

//--- hw/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath and register file sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_AW      5

// instruction word fields
`define F_OPCODE    6:0
`define F_RD        11:7
`define F_FUNCT3    14:12
`define F_RS1       19:15
`define F_RS2       24:20
`define F_FUNCT7    31:25

// major opcodes kept in this core
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011

`endif

//--- hw/rv_core_pkg.sv
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = `OPC_OP,
        OPC_OP_IMM = `OPC_OP_IMM,
        OPC_LUI    = `OPC_LUI,
        OPC_AUIPC  = `OPC_AUIPC,
        OPC_JAL    = `OPC_JAL,
        OPC_JALR   = `OPC_JALR,
        OPC_BRANCH = `OPC_BRANCH
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opa_sel_e;

    typedef enum logic [0:0] {OPB_RS2, OPB_IMM} opb_sel_e;

    typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JAL, BR_JALR} br_kind_e;

    // values follow the branch funct3 field
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd4,
        BR_BGE  = 3'd5,
        BR_BLTU = 3'd6,
        BR_BGEU = 3'd7
    } br_cond_e;

endpackage

//--- hw/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_decoder import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               req,
    input  logic [`XLEN-1:0]   insn,
    input  logic [`XLEN-1:0]   pc,
    output logic               ack,
    output logic [`REG_AW-1:0] rs_addr [2],
    output logic               id_valid,
    output alu_op_e            alu_op,
    output opa_sel_e           opa_sel,
    output opb_sel_e           opb_sel,
    output logic [`XLEN-1:0]   imm,
    output logic [`XLEN-1:0]   id_pc,
    output br_kind_e           br_kind,
    output br_cond_e           br_cond,
    output logic [`REG_AW-1:0] rd,
    output logic               rd_we,
    output logic               undef
);

    logic [`XLEN-1:0] insn_q;
    logic [`XLEN-1:0] pc_q;
    logic             capture;
    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_b;

    // shared funct3 map of OP and OP-IMM, alt picks sub/sra
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'd0:    op = alt ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = alt ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign capture = req && !ack;           // first edge of a new request

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack      <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            id_valid <= capture;
            if (capture) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;                // return to idle phase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            insn_q <= insn;
            pc_q   <= pc;
        end
    end

    assign opcode     = opcode_e'(insn_q[`F_OPCODE]);
    assign funct3     = insn_q[`F_FUNCT3];
    assign funct7     = insn_q[`F_FUNCT7];
    assign rd         = insn_q[`F_RD];
    assign rs_addr[0] = insn_q[`F_RS1];
    assign rs_addr[1] = insn_q[`F_RS2];
    assign id_pc      = pc_q;

    assign imm_i = {{20{insn_q[31]}}, insn_q[31:20]};
    assign imm_u = {insn_q[31:12], 12'b0};
    assign imm_j = {{12{insn_q[31]}}, insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};
    assign imm_b = {{20{insn_q[31]}}, insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};

    always_comb begin
        alu_op  = ALU_ADD;
        opa_sel = OPA_RS1;
        opb_sel = OPB_RS2;
        imm     = '0;
        br_kind = BR_NONE;
        br_cond = br_cond_e'(funct3);
        rd_we   = 1'b0;
        undef   = 1'b0;
        case (opcode)
            OPC_OP: begin
                rd_we  = 1'b1;
                alu_op = f3_to_alu(funct3, funct7[5]);
                if (funct7 == 7'h20) begin
                    undef = (funct3 != 3'd0) && (funct3 != 3'd5);   // only sub and sra
                end else begin
                    undef = (funct7 != 7'h00);
                end
            end
            OPC_OP_IMM: begin
                rd_we   = 1'b1;
                opb_sel = OPB_IMM;
                imm     = imm_i;
                alu_op  = f3_to_alu(funct3, (funct3 == 3'd5) && funct7[5]);
                if (funct3 == 3'd1) begin
                    undef = (funct7 != 7'h00);
                end else if (funct3 == 3'd5) begin
                    undef = (funct7 != 7'h00) && (funct7 != 7'h20);
                end
            end
            OPC_LUI: begin
                rd_we   = 1'b1;
                opa_sel = OPA_ZERO;
                opb_sel = OPB_IMM;
                imm     = imm_u;
                alu_op  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                rd_we   = 1'b1;
                opa_sel = OPA_PC;           // pc of this very instruction
                opb_sel = OPB_IMM;
                imm     = imm_u;
            end
            OPC_JAL: begin
                rd_we   = 1'b1;
                opa_sel = OPA_PC;           // link value pc + 4
                opb_sel = OPB_IMM;
                imm     = imm_j;            // jump offset, used for the target
                br_kind = BR_JAL;
            end
            OPC_JALR: begin
                rd_we   = 1'b1;
                opa_sel = OPA_PC;
                opb_sel = OPB_IMM;
                imm     = imm_i;
                br_kind = BR_JALR;
                undef   = (funct3 != 3'd0);
            end
            OPC_BRANCH: begin
                imm     = imm_b;
                br_kind = BR_COND;
                undef   = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            default: begin
                undef = 1'b1;               // unknown major opcode
            end
        endcase

        // an undefined instruction retires with zero data and no side effects
        if (undef) begin
            rd_we   = 1'b0;
            br_kind = BR_NONE;
            alu_op  = ALU_ADD;
            opa_sel = OPA_ZERO;
            opb_sel = OPB_IMM;
            imm     = '0;
        end
        if (rd == '0) begin
            rd_we = 1'b0;                   // x0 is never written
        end
    end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_execute import rv_core_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               id_valid,
    input  alu_op_e            alu_op,
    input  opa_sel_e           opa_sel,
    input  opb_sel_e           opb_sel,
    input  logic [`XLEN-1:0]   imm,
    input  logic [`XLEN-1:0]   id_pc,
    input  br_kind_e           br_kind,
    input  br_cond_e           br_cond,
    input  logic [`REG_AW-1:0] rd,
    input  logic               rd_we,
    input  logic               undef,
    input  logic [`XLEN-1:0]   src_data [2],
    output logic               wb_we,
    output logic [`REG_AW-1:0] wb_rd,
    output logic [`XLEN-1:0]   wb_data,
    output logic               retire_valid,
    output logic [`REG_AW-1:0] retire_rd,
    output logic               retire_we,
    output logic [`XLEN-1:0]   retire_data,
    output logic               retire_br_taken,
    output logic [`XLEN-1:0]   retire_br_addr,
    output logic               retire_undef
);

    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic               ex_valid;
    logic               ex_rd_we;
    alu_op_e            ex_alu_op;
    logic [`XLEN-1:0]   ex_a;
    logic [`XLEN-1:0]   ex_b;
    logic [`XLEN-1:0]   ex_src0;
    logic [`XLEN-1:0]   ex_src1;
    logic [`XLEN-1:0]   ex_imm;
    logic [`XLEN-1:0]   ex_pc;
    br_kind_e           ex_br_kind;
    br_cond_e           ex_br_cond;
    logic [`REG_AW-1:0] ex_rd;
    logic               ex_undef;
    logic [`XLEN-1:0]   alu_res;
    logic [`XLEN-1:0]   jalr_sum;
    logic [`XLEN-1:0]   br_addr;
    logic               br_taken;
    logic               cond_true;

    always_comb begin
        case (opa_sel)
            OPA_PC:   op_a = id_pc;
            OPA_ZERO: op_a = '0;
            default:  op_a = src_data[0];
        endcase
    end

    // on jumps imm holds the offset, so the link adds a constant 4
    always_comb begin
        if (opb_sel == OPB_RS2) begin
            op_b = src_data[1];
        end else if ((br_kind == BR_JAL) || (br_kind == BR_JALR)) begin
            op_b = `XLEN'(4);
        end else begin
            op_b = imm;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_rd_we <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            ex_rd_we <= id_valid && rd_we;
        end
    end

    // operands are sampled here while the forwarded value is still present
    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_alu_op  <= alu_op;
            ex_a       <= op_a;
            ex_b       <= op_b;
            ex_src0    <= src_data[0];
            ex_src1    <= src_data[1];
            ex_imm     <= imm;
            ex_pc      <= id_pc;
            ex_br_kind <= br_kind;
            ex_br_cond <= br_cond;
            ex_rd      <= rd;
            ex_undef   <= undef;
        end
    end

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_res = ex_a + ex_b;
            ALU_SUB:    alu_res = ex_a - ex_b;
            ALU_SLL:    alu_res = ex_a << ex_b[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(ex_a) < $signed(ex_b)};
            ALU_SLTU:   alu_res = {31'b0, ex_a < ex_b};
            ALU_XOR:    alu_res = ex_a ^ ex_b;
            ALU_SRL:    alu_res = ex_a >> ex_b[4:0];
            ALU_SRA:    alu_res = $unsigned($signed(ex_a) >>> ex_b[4:0]);
            ALU_OR:     alu_res = ex_a | ex_b;
            ALU_AND:    alu_res = ex_a & ex_b;
            ALU_PASS_B: alu_res = ex_b;     // lui
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex_br_cond)
            BR_BEQ:  cond_true = (ex_src0 == ex_src1);
            BR_BNE:  cond_true = (ex_src0 != ex_src1);
            BR_BLT:  cond_true = ($signed(ex_src0) < $signed(ex_src1));
            BR_BGE:  cond_true = ($signed(ex_src0) >= $signed(ex_src1));
            BR_BLTU: cond_true = (ex_src0 < ex_src1);
            BR_BGEU: cond_true = (ex_src0 >= ex_src1);
            default: cond_true = 1'b0;
        endcase
    end

    assign jalr_sum = ex_src0 + ex_imm;

    always_comb begin
        br_taken = 1'b0;
        br_addr  = '0;
        case (ex_br_kind)
            BR_COND: begin
                br_taken = cond_true;
                br_addr  = ex_pc + ex_imm;
            end
            BR_JAL: begin
                br_taken = 1'b1;
                br_addr  = ex_pc + ex_imm;
            end
            BR_JALR: begin
                br_taken = 1'b1;
                br_addr  = {jalr_sum[`XLEN-1:1], 1'b0};   // bit 0 cleared
            end
            default: begin
                br_taken = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
            wb_we        <= 1'b0;
        end else begin
            retire_valid <= ex_valid;       // one cycle per instruction
            wb_we        <= ex_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd           <= ex_rd;
            wb_data         <= alu_res;
            retire_br_taken <= br_taken;
            retire_br_addr  <= br_addr;
            retire_undef    <= ex_undef;
        end
    end

    assign retire_rd   = wb_rd;
    assign retire_we   = wb_we;
    assign retire_data = wb_data;

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [`REG_AW-1:0] rs_addr [2],
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    output logic [`XLEN-1:0]   rf_data [2]
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;         // rd of x0 never arrives here
        end
    end

    // asynchronous read, bypass of the same-cycle write sits outside
    assign rf_data[0] = regs[rs_addr[0]];
    assign rf_data[1] = regs[rs_addr[1]];

endmodule

//--- rv_core.f
+incdir+hw
+incdir+tb
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/operand_forward.sv
hw/rv_execute.sv
hw/rv_core.sv
tb/rv_core_tb.sv

//--- tb/rv_core_model.svh
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// expected retire report of one instruction
typedef struct packed {
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
    logic        chk_data;   // data and rd are only defined for writing instructions
    logic        taken;
    logic [31:0] addr;
    logic        chk_addr;
    logic        undef;
} expect_t;

logic [31:0] model_regs [32];   // architectural register state

function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'd0:    return alt ? x - y : x + y;
        3'd1:    return x << y[4:0];
        3'd2:    return {31'b0, $signed(x) < $signed(y)};
        3'd3:    return {31'b0, x < y};
        3'd4:    return x ^ y;
        3'd5:    return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6:    return x | y;
        default: return x & y;
    endcase
endfunction

// RV32I semantics of one word, updates model_regs in program order
function automatic expect_t predict(input logic [31:0] w, input logic [31:0] pcv);
    expect_t     e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ii;
    logic [31:0] res;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        legal;
    logic        writes;
    logic        flow;
    e      = '0;
    a      = model_regs[w[19:15]];
    b      = model_regs[w[24:20]];
    f3     = w[14:12];
    f7     = w[31:25];
    ii     = {{20{w[31]}}, w[31:20]};
    legal  = 1'b1;
    writes = 1'b1;
    flow   = 1'b0;
    res    = '0;
    e.rd   = w[11:7];
    case (w[6:0])
        `OPC_OP: begin
            legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            res   = model_alu(f3, f7[5], a, b);
        end
        `OPC_OP_IMM: begin
            if (f3 == 3'd1) begin
                legal = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            end
            res = model_alu(f3, (f3 == 3'd5) && f7[5], a, ii);   // shamt sits in ii[4:0]
        end
        `OPC_LUI: begin
            res = {w[31:12], 12'b0};
        end
        `OPC_AUIPC: begin
            res = pcv + {w[31:12], 12'b0};
        end
        `OPC_JAL: begin
            flow    = 1'b1;
            res     = pcv + 32'd4;
            e.taken = 1'b1;
            e.addr  = pcv + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        `OPC_JALR: begin
            flow    = 1'b1;
            legal   = (f3 == 3'd0);
            res     = pcv + 32'd4;
            e.taken = 1'b1;
            e.addr  = (a + ii) & ~32'd1;
        end
        `OPC_BRANCH: begin
            flow   = 1'b1;
            writes = 1'b0;
            e.addr = pcv + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            case (f3)
                BR_BEQ:  e.taken = (a == b);
                BR_BNE:  e.taken = (a != b);
                BR_BLT:  e.taken = ($signed(a) < $signed(b));
                BR_BGE:  e.taken = ($signed(a) >= $signed(b));
                BR_BLTU: e.taken = (a < b);
                BR_BGEU: e.taken = (a >= b);
                default: legal = 1'b0;
            endcase
        end
        default: begin
            legal = 1'b0;                   // load, store, system and the rest
        end
    endcase
    e.undef    = !legal;
    e.taken    = e.taken && legal;
    e.chk_data = legal && writes;
    e.chk_addr = legal && flow;
    e.we       = legal && writes && (e.rd != 5'd0);
    e.data     = res;
    if (e.we) begin
        model_regs[e.rd] = res;
    end
    return e;
endfunction

function automatic logic [31:0] alu_word(input logic imm_class, input logic [31:0] r,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = r[14:12];
    f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && r[30]) ? 7'h20 : 7'h00;
    if (!imm_class) begin
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    end
    case (r[1:0])
        2'd0: return {r[31:12], rd, `OPC_LUI};
        2'd1: return {r[31:12], rd, `OPC_AUIPC};
        default: begin
            if ((f3 == 3'd1) || (f3 == 3'd5)) begin
                return {f7, r[24:20], rs1, f3, rd, `OPC_OP_IMM};   // shifts
            end
            return {r[31:20], rs1, f3, rd, `OPC_OP_IMM};
        end
    endcase
endfunction

function automatic logic [31:0] flow_word(input logic [31:0] r,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
    logic [2:0] f3;
    f3 = r[14:12];
    if (f3[2:1] == 2'b01) begin
        f3[2] = 1'b1;                       // map the two reserved codes onto real ones
    end
    case (r[1:0])
        2'd0:    return {r[31:12], rd, `OPC_JAL};
        2'd1:    return {r[31:20], rs1, 3'b000, rd, `OPC_JALR};
        default: return {r[31:25], rs2, rs1, f3, r[11:7], `OPC_BRANCH};
    endcase
endfunction

function automatic logic [31:0] bad_word(input logic [31:0] r,
        input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
    case (r[2:0])
        3'd0:    return {r[31:7], 7'b0000011};                          // load
        3'd1:    return {r[31:7], 7'b0100011};                          // store
        3'd2:    return {7'h01, rs2, rs1, r[14:12], rd, `OPC_OP};       // M extension
        3'd3:    return {7'h20, r[24:20], rs1, 3'd1, rd, `OPC_OP_IMM};  // slli with funct7
        3'd4:    return {r[31:25], rs2, rs1, 2'b01, r[12], r[11:7], `OPC_BRANCH};
        3'd5:    return {r[31:20], rs1, r[14:12] | 3'd1, rd, `OPC_JALR};
        default: return {r[31:7], 7'b1110011};                          // system
    endcase
endfunction

// kind 0 OP, 1 OP-IMM/LUI/AUIPC, 2 jumps and branches, 3 undefined, else any ALU form
function automatic logic [31:0] gen_insn(input int kind, input logic [4:0] prev,
                                         input logic dep, input logic rd_zero);
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r  = $urandom;
    s  = $urandom;
    rd = s[4:0];
    if (rd == 5'd0) begin
        rd = 5'd1;
    end
    if (rd_zero) begin
        rd = 5'd0;
    end
    rs1 = (dep || s[5]) ? prev : s[10:6];   // lean on the previous rd
    rs2 = ((dep && s[11]) || s[12]) ? prev : s[17:13];
    case (kind)
        0:       return alu_word(1'b0, r, rs1, rs2, rd);
        1:       return alu_word(1'b1, r, rs1, rs2, rd);
        2:       return flow_word(r, rs1, rs2, rd);
        3:       return bad_word(r, rs1, rs2, rd);
        default: return alu_word(s[20], r, rs1, rs2, rd);
    endcase
endfunction

`endif

//--- tb/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_core_defines.svh"

module rv_core_tb import rv_core_pkg::*; ();

    logic               clk;
    logic               arst_n;
    logic               req;
    logic [`XLEN-1:0]   insn;
    logic [`XLEN-1:0]   pc;
    logic               ack;
    logic               retire_valid;
    logic [`REG_AW-1:0] retire_rd;
    logic               retire_we;
    logic [`XLEN-1:0]   retire_data;
    logic               retire_br_taken;
    logic [`XLEN-1:0]   retire_br_addr;
    logic               retire_undef;

    int      errors;
    int      checks;
    int      tests;
    logic    hung;                          // a handshake or retire timed out

    `include "rv_core_model.svh"

    expect_t exp_q [$];                     // issued, not yet retired

    rv_core UUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .req             (req),
        .insn            (insn),
        .pc              (pc),
        .ack             (ack),
        .retire_valid    (retire_valid),
        .retire_rd       (retire_rd),
        .retire_we       (retire_we),
        .retire_data     (retire_data),
        .retire_br_taken (retire_br_taken),
        .retire_br_addr  (retire_br_addr),
        .retire_undef    (retire_undef)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // four-phase handshake for one instruction at a random aligned pc
    task automatic issue_insn(input logic [31:0] w, input int gap);
        expect_t     e;
        logic [31:0] r;
        logic [31:0] pcv;
        int          n;
        r   = $urandom;
        pcv = {r[31:2], 2'b00};
        e   = predict(w, pcv);
        exp_q.push_back(e);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        req  = 1'b1;
        insn = w;
        pc   = pcv;
        n    = 0;
        while (!ack && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ack) begin
            $display("timeout: ack did not rise within 20 cycles of req");
            errors++;
            hung = 1'b1;
        end else begin
            req = 1'b0;
            n   = 0;
            while (ack && n < 20) begin
                @(posedge clk);
                #1;
                n++;
            end
            if (ack) begin
                $display("timeout: ack stayed high 20 cycles after req dropped");
                errors++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic drain_retires();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d instructions did not retire within 20 cycles", exp_q.size());
            errors++;
            hung = 1'b1;
            exp_q.delete();
        end
    endtask

    // lui + addi into every register so the operands are not all zero
    task automatic fill_regs();
        logic [31:0] r;
        logic [4:0]  ri;
        for (int i = 1; i < 32 && !hung; i++) begin
            r  = $urandom;
            ri = i[4:0];
            issue_insn({r[31:12], ri, `OPC_LUI}, 0);
            issue_insn({r[11:0], ri, 3'b000, ri, `OPC_OP_IMM}, 0);
        end
    endtask

    task automatic run_test(input int id, input string name);
        int          err0;
        logic [4:0]  prev;
        logic [31:0] w;
        logic [31:0] r;
        err0 = errors;
        prev = 5'd1;
        if (id == 1) begin
            fill_regs();
        end
        for (int k = 0; k < 60 && !hung; k++) begin
            r = $urandom;
            case (id)
                1:       w = gen_insn(0, prev, 1'b0, 1'b0);
                2:       w = gen_insn(1, prev, 1'b0, 1'b0);
                3:       w = gen_insn(4, prev, 1'b1, 1'b0);
                4:       w = gen_insn(2, prev, 1'b0, 1'b0);
                5:       w = gen_insn(k[0] ? 4 : 3, prev, k[0], 1'b0);
                default: w = gen_insn(4, prev, k[0], !k[0]);   // rd = x0, then read x0
            endcase
            issue_insn(w, (id == 3) ? 0 : {30'b0, r[1:0]});   // back to back in test 3
            prev = w[11:7];
        end
        drain_retires();
        tests++;
        $display("test %0d %s: %0d errors", id, name, errors - err0);
    endtask

    // retire monitor, one report per cycle of retire_valid
    initial begin
        expect_t e;
        forever begin
            @(posedge clk);
            #1;
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    $display("retire_valid was high with no instruction pending at %0t ns",
                             $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_field("retire_undef", {31'b0, retire_undef}, {31'b0, e.undef});
                    check_field("retire_we", {31'b0, retire_we}, {31'b0, e.we});
                    check_field("retire_br_taken", {31'b0, retire_br_taken}, {31'b0, e.taken});
                    if (e.chk_data) begin
                        check_field("retire_rd", {27'b0, retire_rd}, {27'b0, e.rd});
                        check_field("retire_data", retire_data, e.data);
                    end
                    if (e.chk_addr) begin
                        check_field("retire_br_addr", retire_br_addr, e.addr);
                    end
                end
            end
        end
    end

    initial begin
        req    = 1'b0;
        insn   = '0;
        pc     = '0;
        arst_n = 1'b0;
        errors = 0;
        checks = 0;
        tests  = 0;
        hung   = 1'b0;
        void'($urandom(32'h3738));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        run_test(1, "register-register alu");
        run_test(2, "op-imm, lui, auipc");
        run_test(3, "back-to-back forwarding");
        run_test(4, "branches, jal, jalr");
        run_test(5, "undefined encodings");
        run_test(6, "writes to x0");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
